//--- angle_controller.sv
// ==========================================================
// outer angle loop of the flight controller
// pipelined map, scale and limit steps under one sequencer;
// start may pulse every cycle, done follows three edges on
// ==========================================================
`timescale 1ns/1ps

module angle_controller (
	input  logic                us_clk,
	input  logic                resetn,
	input  logic                start,
	input  flight_pkg::rx_val_t throttle_target,
	input  flight_pkg::rx_val_t yaw_target,
	input  flight_pkg::rx_val_t pitch_target,
	input  flight_pkg::rx_val_t roll_target,
	input  flight_pkg::rate_t   pitch_actual,
	input  flight_pkg::rate_t   roll_actual,
	output flight_pkg::rate_t   throttle_rate,
	output flight_pkg::rate_t   yaw_rate,
	output flight_pkg::rate_t   pitch_rate,
	output flight_pkg::rate_t   roll_rate,
	output flight_pkg::rate_t   pitch_error,
	output flight_pkg::rate_t   roll_error,
	output logic                done,
	output logic                busy
);

	// step enables
	logic map_en;
	logic scale_en;
	logic limit_en;

	// mapper to scaler
	flight_pkg::wide_t mapped_throttle;
	flight_pkg::wide_t mapped_yaw;
	flight_pkg::wide_t mapped_pitch;
	flight_pkg::wide_t mapped_roll;

	// scaler to limiter
	flight_pkg::wide_t scaled_throttle;
	flight_pkg::wide_t scaled_yaw;
	flight_pkg::wide_t scaled_pitch;
	flight_pkg::wide_t scaled_roll;

	angle_sequencer angle_sequencer_inst (
		.us_clk   (us_clk),
		.resetn   (resetn),
		.start    (start),
		.map_en   (map_en),
		.scale_en (scale_en),
		.limit_en (limit_en),
		.done     (done),
		.busy     (busy)
	);

	setpoint_mapper setpoint_mapper_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.map_en          (map_en),
		.throttle_target (throttle_target),
		.yaw_target      (yaw_target),
		.pitch_target    (pitch_target),
		.roll_target     (roll_target),
		.pitch_actual    (pitch_actual),
		.roll_actual     (roll_actual),
		.mapped_throttle (mapped_throttle),
		.mapped_yaw      (mapped_yaw),
		.mapped_pitch    (mapped_pitch),
		.mapped_roll     (mapped_roll),
		.pitch_error     (pitch_error),
		.roll_error      (roll_error)
	);

	gain_scaler gain_scaler_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.scale_en        (scale_en),
		.mapped_throttle (mapped_throttle),
		.mapped_yaw      (mapped_yaw),
		.mapped_pitch    (mapped_pitch),
		.mapped_roll     (mapped_roll),
		.scaled_throttle (scaled_throttle),
		.scaled_yaw      (scaled_yaw),
		.scaled_pitch    (scaled_pitch),
		.scaled_roll     (scaled_roll)
	);

	rate_limiter rate_limiter_inst (
		.us_clk          (us_clk),
		.resetn          (resetn),
		.limit_en        (limit_en),
		.scaled_throttle (scaled_throttle),
		.scaled_yaw      (scaled_yaw),
		.scaled_pitch    (scaled_pitch),
		.scaled_roll     (scaled_roll),
		.throttle_rate   (throttle_rate),
		.yaw_rate        (yaw_rate),
		.pitch_rate      (pitch_rate),
		.roll_rate       (roll_rate)
	);

endmodule

//--- angle_controller_chk.sv
// ============================================================
// protocol checker bound into the angle controller
// done timing against start, busy during done, rate hold
// ============================================================
`timescale 1ns/1ps

module angle_controller_chk (
	input logic              us_clk,
	input logic              resetn,
	input logic              start,
	input logic              limit_en,
	input logic              done,
	input logic              busy,
	input flight_pkg::rate_t throttle_rate,
	input flight_pkg::rate_t yaw_rate,
	input flight_pkg::rate_t pitch_rate,
	input flight_pkg::rate_t roll_rate
);

	// count of failed assertions, read at end of run
	int failures = 0;

	done_has_start: assert property (@(posedge us_clk) disable iff (!resetn)
		done |-> $past(start, 3))
	else begin
		$error("done without a start three cycles before");
		failures++;
	end

	start_gives_done: assert property (@(posedge us_clk) disable iff (!resetn)
		$past(start, 3) |-> done)
	else begin
		$error("start was not followed by done three cycles later");
		failures++;
	end

	busy_with_done: assert property (@(posedge us_clk) disable iff (!resetn)
		done |-> busy)
	else begin
		$error("done high while busy is low");
		failures++;
	end

	// rates only move on the edge that sampled limit_en
	rates_hold: assert property (@(posedge us_clk) disable iff (!resetn)
		!$past(limit_en) |-> ($stable(throttle_rate) && $stable(yaw_rate)
			&& $stable(pitch_rate) && $stable(roll_rate)))
	else begin
		$error("rate output changed without limit_en");
		failures++;
	end

endmodule

bind angle_controller angle_controller_chk angle_controller_chk_inst (
	.us_clk        (us_clk),
	.resetn        (resetn),
	.start         (start),
	.limit_en      (limit_en),
	.done          (done),
	.busy          (busy),
	.throttle_rate (throttle_rate),
	.yaw_rate      (yaw_rate),
	.pitch_rate    (pitch_rate),
	.roll_rate     (roll_rate)
);

//--- angle_controller_tb.sv
// ============================================================
// testbench for the pipelined angle loop
// reads tests from angle_stimulus.txt, drives starts on the
// falling edge and checks every done against the file's values
// ============================================================
`timescale 1ns/1ps

module angle_controller_tb;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_TESTS    = 32;
	// columns after the test name: gap, six inputs, six expected
	localparam int NUM_COLS = 13;
	localparam int COL_GAP  = 0;
	localparam int COL_IN   = 1;
	localparam int COL_EXP  = 7;

	logic                us_clk;
	logic                resetn;
	logic                start;
	flight_pkg::rx_val_t throttle_target;
	flight_pkg::rx_val_t yaw_target;
	flight_pkg::rx_val_t pitch_target;
	flight_pkg::rx_val_t roll_target;
	flight_pkg::rate_t   pitch_actual;
	flight_pkg::rate_t   roll_actual;
	flight_pkg::rate_t   throttle_rate;
	flight_pkg::rate_t   yaw_rate;
	flight_pkg::rate_t   pitch_rate;
	flight_pkg::rate_t   roll_rate;
	flight_pkg::rate_t   pitch_error;
	flight_pkg::rate_t   roll_error;
	logic                done;
	logic                busy;

	string       test_names [MAX_TESTS];
	int          stim [MAX_TESTS][NUM_COLS];
	int          eff_gap [MAX_TESTS];
	bit          check_errors [MAX_TESTS];
	int          num_tests;
	// test indexes in flight, oldest first
	int          pending [$];
	bit          plan_ready;
	int          watchdog_cycles;
	int          tests_passed;
	int          tests_failed;
	int          other_errors;
	logic [31:0] lcg_state;

	angle_controller angle_controller_inst (.*);

	always #(CLK_PERIOD / 2) us_clk = ~us_clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic load_stimulus();
		int    fd;
		int    n;
		int    c;
		string line;
		string name;
		int    v [NUM_COLS];
		fd = $fopen("angle_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file angle_stimulus.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
				v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11], v[12]);
			if (n != NUM_COLS + 1) begin
				$display("stimulus line could not be parsed: %s", line);
				other_errors++;
				continue;
			end
			test_names[num_tests] = name;
			for (c = 0; c < NUM_COLS; c++)
				stim[num_tests][c] = v[c];
			num_tests++;
		end
		$fclose(fd);
	endtask

	task automatic check_field(input string test, input string field, input int expected,
		input int actual, inout bit ok);
		assert (actual == expected)
		else begin
			$display("Error: %s %s expected %0d actual %0d", test, field, expected, actual);
			ok = 1'b0;
		end
	endtask

	task automatic finish_test(input string test, input bit ok);
		if (ok) begin
			tests_passed++;
			$display("test %s: pass", test);
		end else begin
			tests_failed++;
			$display("test %s: FAIL", test);
		end
	endtask

	task automatic check_result(input int idx);
		bit    ok;
		string name;
		ok = 1'b1;
		name = test_names[idx];
		check_field(name, "throttle_rate", stim[idx][COL_EXP], int'(throttle_rate), ok);
		check_field(name, "yaw_rate", stim[idx][COL_EXP + 1], int'(yaw_rate), ok);
		check_field(name, "pitch_rate", stim[idx][COL_EXP + 2], int'(pitch_rate), ok);
		check_field(name, "roll_rate", stim[idx][COL_EXP + 3], int'(roll_rate), ok);
		// a later start rewrites the errors before this done
		if (check_errors[idx]) begin
			check_field(name, "pitch_error", stim[idx][COL_EXP + 4], int'(pitch_error), ok);
			check_field(name, "roll_error", stim[idx][COL_EXP + 5], int'(roll_error), ok);
		end
		finish_test(name, ok);
	endtask

	task automatic check_idle(input string test, input bit outputs_zero);
		bit ok;
		ok = 1'b1;
		check_field(test, "done", 0, int'(done), ok);
		check_field(test, "busy", 0, int'(busy), ok);
		if (outputs_zero) begin
			check_field(test, "throttle_rate", 0, int'(throttle_rate), ok);
			check_field(test, "yaw_rate", 0, int'(yaw_rate), ok);
			check_field(test, "pitch_rate", 0, int'(pitch_rate), ok);
			check_field(test, "roll_rate", 0, int'(roll_rate), ok);
			check_field(test, "pitch_error", 0, int'(pitch_error), ok);
			check_field(test, "roll_error", 0, int'(roll_error), ok);
		end
		finish_test(test, ok);
	endtask

	task automatic apply_test(input int idx);
		throttle_target = flight_pkg::rx_val_t'(stim[idx][COL_IN]);
		yaw_target      = flight_pkg::rx_val_t'(stim[idx][COL_IN + 1]);
		pitch_target    = flight_pkg::rx_val_t'(stim[idx][COL_IN + 2]);
		roll_target     = flight_pkg::rx_val_t'(stim[idx][COL_IN + 3]);
		pitch_actual    = flight_pkg::rate_t'(stim[idx][COL_IN + 4]);
		roll_actual     = flight_pkg::rate_t'(stim[idx][COL_IN + 5]);
		start           = 1'b1;
		pending.push_back(idx);
	endtask

	// inputs are don't care while start is low
	task automatic scramble_inputs();
		logic [31:0] r;
		r = next_rand();
		throttle_target = r[7:0];
		yaw_target      = r[15:8];
		pitch_target    = r[23:16];
		roll_target     = r[31:24];
		r = next_rand();
		pitch_actual    = r[15:0];
		roll_actual     = r[31:16];
	endtask

	always @(negedge us_clk) begin
		if (resetn && done) begin
			if (pending.size() == 0) begin
				$display("done pulsed while no sample was in flight");
				other_errors++;
			end else begin
				check_result(pending.pop_front());
			end
		end
	end

	initial begin
		int          i;
		int          total_gap;
		int          chk_failures;
		logic [31:0] r;
		us_clk          = 1'b0;
		resetn          = 1'b0;
		start           = 1'b0;
		throttle_target = '0;
		yaw_target      = '0;
		pitch_target    = '0;
		roll_target     = '0;
		pitch_actual    = '0;
		roll_actual     = '0;
		lcg_state       = 32'h3bb1;
		num_tests       = 0;
		tests_passed    = 0;
		tests_failed    = 0;
		other_errors    = 0;
		load_stimulus();

		// random idle stretch only behind isolated tests
		total_gap = 0;
		for (i = 0; i < num_tests; i++) begin
			eff_gap[i] = stim[i][COL_GAP];
			if (eff_gap[i] != 0) begin
				r = next_rand();
				eff_gap[i] += 4 + int'(r[17:16]);
			end
			total_gap += eff_gap[i];
			check_errors[i] = (eff_gap[i] >= 2) || (i == num_tests - 1);
		end
		watchdog_cycles = num_tests + total_gap + 10;
		plan_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge us_clk);
		@(negedge us_clk);
		resetn = 1'b1;
		@(negedge us_clk);
		check_idle("reset", 1'b1);

		for (i = 0; i < num_tests; i++) begin
			@(negedge us_clk);
			apply_test(i);
			repeat (eff_gap[i]) begin
				@(negedge us_clk);
				start = 1'b0;
				scramble_inputs();
			end
		end
		@(negedge us_clk);
		start = 1'b0;
		while (pending.size() != 0)
			@(negedge us_clk);
		repeat (2) @(negedge us_clk);
		check_idle("drain", 1'b0);

		chk_failures = angle_controller_inst.angle_controller_chk_inst.failures;
		$display("%0d tests passed, %0d failed, %0d protocol errors, %0d assertion failures",
			tests_passed, tests_failed, other_errors, chk_failures);
		if (tests_failed == 0 && other_errors == 0 && chk_failures == 0 && num_tests > 0
			&& tests_passed == num_tests + 2) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// limit follows the planned length of the run
	initial begin
		wait (plan_ready);
		repeat (RESET_CYCLES + 1 + watchdog_cycles) @(posedge us_clk);
		$display("timeout after %0d cycles, %0d samples never produced a done",
			watchdog_cycles, pending.size());
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- angle_sequencer.sv
// ==========================================================
// control for the three-step angle pipeline
// tracks which step holds a sample, issues the step enables
// and raises done three edges after start was sampled
// ==========================================================
`timescale 1ns/1ps

module angle_sequencer (
	input  logic us_clk,
	input  logic resetn,
	input  logic start,
	output logic map_en,
	output logic scale_en,
	output logic limit_en,
	output logic done,
	output logic busy
);

	// bit 0 mapper, bit 1 scaler, bit 2 limiter holds a sample
	logic [2:0] valid;
	flight_pkg::seq_state_t state;
	flight_pkg::seq_state_t state_next;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			valid <= 3'b000;
		end else begin
			valid <= {valid[1:0], start};
		end
	end

	// stays running while anything will be held after this edge
	always_comb begin
		case (state)
			flight_pkg::SEQ_IDLE: begin
				state_next = start ? flight_pkg::SEQ_RUN : flight_pkg::SEQ_IDLE;
			end
			flight_pkg::SEQ_RUN: begin
				if (start || valid[0] || valid[1])
					state_next = flight_pkg::SEQ_RUN;
				else
					state_next = flight_pkg::SEQ_IDLE;
			end
			default: begin
				state_next = flight_pkg::SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= flight_pkg::SEQ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign map_en   = start;
	assign scale_en = valid[0];
	assign limit_en = valid[1];
	assign done     = valid[2];
	assign busy     = (state == flight_pkg::SEQ_RUN);

endmodule

//--- angle_stimulus.txt
# name gap throttle yaw pitch roll pitch_actual roll_actual, then expected
# throttle_rate yaw_rate pitch_rate roll_rate pitch_error roll_error, decimal 12.4
centred 3 125 125 125 125 0 0 2000 0 0 0 0 0
pitch_correct 3 125 125 125 125 160 0 2000 0 -320 0 -160 0
roll_sign 3 125 125 125 125 0 160 2000 0 0 360 0 160
clamp_high 3 250 250 250 250 -800 800 4000 500 1600 1600 1300 1300
clamp_low 3 0 0 0 0 800 -800 0 -500 -1600 -1600 -1300 -1300
round_neg_odd 2 125 125 125 124 0 -1 2000 0 0 -12 0 -5
round_neg_frac 2 125 125 125 125 0 -3 2000 0 0 -7 0 -3
round_pos_frac 2 125 125 125 125 0 3 2000 0 0 6 0 3
mixed_axes 4 100 200 100 150 50 -20 1600 300 -300 180 -150 80
b2b_first 0 10 130 140 110 0 0 160 20 120 -135 60 -60
b2b_second 0 20 120 110 140 16 -16 320 -20 -152 99 -76 44
b2b_third 3 30 125 125 125 -33 -33 480 0 66 -75 33 -33
pitch_at_limit 3 125 125 250 125 -300 0 2000 0 1600 0 800 0
pitch_over_limit 3 125 125 250 125 -301 0 2000 0 1600 0 801 0
yaw_full 3 125 250 125 125 0 0 2000 500 0 0 0 0
throttle_zero 3 0 125 125 125 0 0 0 0 0 0 0 0
roll_near_limit 1 125 125 125 0 0 -210 2000 0 0 -1598 0 -710

//--- flight_pkg.sv
// ==========================================================
// shared types and fixed constants for the angle loop
// widths, per-axis gains, rate limits and sequencer states
// referenced by scoped name from every pipeline step
// ==========================================================
package flight_pkg;

	// receiver target, 0 to 250
	typedef logic [7:0] rx_val_t;
	// 12.4 signed angle or rate
	typedef logic signed [15:0] rate_t;
	// datapath working width, holds products without overflow
	typedef logic signed [31:0] wide_t;
	typedef logic [3:0] shift_t;

	typedef enum logic [0:0] {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

	// mapping: target << 2 then minus offset gives +/-500
	localparam shift_t RX_SHIFT       = 4'd2;
	localparam wide_t  MAP_OFFSET     = 32'sd500;
	localparam shift_t THROTTLE_SHIFT = 4'd4;

	// gains as multiply then arithmetic shift right
	localparam wide_t  YAW_MULT           = 32'sd1;
	localparam shift_t YAW_SHIFT          = 4'd0;
	localparam wide_t  PITCH_MULT         = 32'sd32;
	localparam shift_t PITCH_SHIFT        = 4'd4;
	localparam wide_t  ROLL_MULT          = 32'sd36;
	localparam shift_t ROLL_SHIFT         = 4'd4;
	localparam wide_t  THROTTLE_MULT      = 32'sd1;
	localparam shift_t THROTTLE_SHIFT_DIV = 4'd0;

	// rate limits in 12.4
	localparam wide_t THROTTLE_MIN = 32'sd0;
	localparam wide_t THROTTLE_MAX = 32'sd250 <<< THROTTLE_SHIFT;
	localparam wide_t YAW_MIN      = -32'sd1600;
	localparam wide_t YAW_MAX      = 32'sd1600;
	localparam wide_t PITCH_MIN    = -32'sd1600;
	localparam wide_t PITCH_MAX    = 32'sd1600;
	localparam wide_t ROLL_MIN     = -32'sd1600;
	localparam wide_t ROLL_MAX     = 32'sd1600;

endpackage

//--- gain_scaler.sv
// ==========================================================
// second pipeline step: fixed per-axis gain applied as a
// multiply followed by an arithmetic right shift
// registers on scale_en, results feed the rate limiter
// ==========================================================
`timescale 1ns/1ps

module gain_scaler (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              scale_en,
	input  flight_pkg::wide_t mapped_throttle,
	input  flight_pkg::wide_t mapped_yaw,
	input  flight_pkg::wide_t mapped_pitch,
	input  flight_pkg::wide_t mapped_roll,
	output flight_pkg::wide_t scaled_throttle,
	output flight_pkg::wide_t scaled_yaw,
	output flight_pkg::wide_t scaled_pitch,
	output flight_pkg::wide_t scaled_roll
);

	// >>> drops fraction bits, rounds toward minus infinity
	function automatic flight_pkg::wide_t scale(
		input flight_pkg::wide_t  v,
		input flight_pkg::wide_t  mult,
		input flight_pkg::shift_t sh
	);
		flight_pkg::wide_t prod;
		prod = v * mult;
		return prod >>> sh;
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			scaled_throttle <= '0;
			scaled_yaw      <= '0;
			scaled_pitch    <= '0;
			scaled_roll     <= '0;
		end else if (scale_en) begin
			scaled_throttle <= scale(mapped_throttle, flight_pkg::THROTTLE_MULT,
				flight_pkg::THROTTLE_SHIFT_DIV);
			scaled_yaw      <= scale(mapped_yaw, flight_pkg::YAW_MULT, flight_pkg::YAW_SHIFT);
			scaled_pitch    <= scale(mapped_pitch, flight_pkg::PITCH_MULT,
				flight_pkg::PITCH_SHIFT);
			scaled_roll     <= scale(mapped_roll, flight_pkg::ROLL_MULT, flight_pkg::ROLL_SHIFT);
		end
	end

endmodule

//--- rate_limiter.sv
// ==========================================================
// third pipeline step: clamps each axis to its rate range
// and holds the 16-bit rate commands until the next
// limit_en, outputs go straight to the inner rate loop
// ==========================================================
`timescale 1ns/1ps

module rate_limiter (
	input  logic              us_clk,
	input  logic              resetn,
	input  logic              limit_en,
	input  flight_pkg::wide_t scaled_throttle,
	input  flight_pkg::wide_t scaled_yaw,
	input  flight_pkg::wide_t scaled_pitch,
	input  flight_pkg::wide_t scaled_roll,
	output flight_pkg::rate_t throttle_rate,
	output flight_pkg::rate_t yaw_rate,
	output flight_pkg::rate_t pitch_rate,
	output flight_pkg::rate_t roll_rate
);

	// compare at full width, then keep the low 16 bits
	function automatic flight_pkg::rate_t clamp(
		input flight_pkg::wide_t v,
		input flight_pkg::wide_t lo,
		input flight_pkg::wide_t hi
	);
		flight_pkg::wide_t lim;
		if (v > hi)
			lim = hi;
		else if (v < lo)
			lim = lo;
		else
			lim = v;
		return lim[15:0];
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_rate <= '0;
			yaw_rate      <= '0;
			pitch_rate    <= '0;
			roll_rate     <= '0;
		end else if (limit_en) begin
			throttle_rate <= clamp(scaled_throttle, flight_pkg::THROTTLE_MIN,
				flight_pkg::THROTTLE_MAX);
			yaw_rate      <= clamp(scaled_yaw, flight_pkg::YAW_MIN, flight_pkg::YAW_MAX);
			pitch_rate    <= clamp(scaled_pitch, flight_pkg::PITCH_MIN, flight_pkg::PITCH_MAX);
			roll_rate     <= clamp(scaled_roll, flight_pkg::ROLL_MIN, flight_pkg::ROLL_MAX);
		end
		// otherwise hold, next sample overwrites
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the angle controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module angle_controller_tb -f tb.f -o angle_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
	cat build.log
	echo "build failed with status $build_status"
	exit 1
fi

./obj_dir/angle_sim +verilator+error+limit+1000 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1

//--- setpoint_mapper.sv
// ==========================================================
// first pipeline step: recentres the receiver targets and
// subtracts the IMU attitude to form the angle errors
// registers on map_en, results feed the gain scaler
// ==========================================================
`timescale 1ns/1ps

module setpoint_mapper (
	input  logic                us_clk,
	input  logic                resetn,
	input  logic                map_en,
	input  flight_pkg::rx_val_t throttle_target,
	input  flight_pkg::rx_val_t yaw_target,
	input  flight_pkg::rx_val_t pitch_target,
	input  flight_pkg::rx_val_t roll_target,
	input  flight_pkg::rate_t   pitch_actual,
	input  flight_pkg::rate_t   roll_actual,
	output flight_pkg::wide_t   mapped_throttle,
	output flight_pkg::wide_t   mapped_yaw,
	output flight_pkg::wide_t   mapped_pitch,
	output flight_pkg::wide_t   mapped_roll,
	output flight_pkg::rate_t   pitch_error,
	output flight_pkg::rate_t   roll_error
);

	localparam int PAD_W = $bits(flight_pkg::wide_t) - $bits(flight_pkg::rx_val_t);

	flight_pkg::wide_t pitch_next;
	flight_pkg::wide_t roll_next;

	// 0..250 onto -500..+500, i.e. +/-31.25 deg in 12.4
	function automatic flight_pkg::wide_t recentre(input flight_pkg::rx_val_t v);
		flight_pkg::wide_t ext;
		ext = {{PAD_W{1'b0}}, v};
		return (ext <<< flight_pkg::RX_SHIFT) - flight_pkg::MAP_OFFSET;
	endfunction

	// imu roll sign is flipped, so it is added
	assign pitch_next = recentre(pitch_target) - flight_pkg::wide_t'(pitch_actual);
	assign roll_next  = recentre(roll_target) + flight_pkg::wide_t'(roll_actual);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			mapped_throttle <= '0;
			mapped_yaw      <= '0;
			mapped_pitch    <= '0;
			mapped_roll     <= '0;
			pitch_error     <= '0;
			roll_error      <= '0;
		end else if (map_en) begin
			mapped_throttle <= {{PAD_W{1'b0}}, throttle_target} <<< flight_pkg::THROTTLE_SHIFT;
			mapped_yaw      <= recentre(yaw_target);
			mapped_pitch    <= pitch_next;
			mapped_roll     <= roll_next;
			// errors leave here, ahead of the matching rates
			pitch_error     <= pitch_next[15:0];
			roll_error      <= roll_next[15:0];
		end
	end

endmodule

//--- tb.f
flight_pkg.sv
angle_sequencer.sv
setpoint_mapper.sv
gain_scaler.sv
rate_limiter.sv
angle_controller.sv
angle_controller_chk.sv
angle_controller_tb.sv
